/* include/rv_consts.svh */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Datapath and address width
`define RV_XLEN 32

// Register file geometry
`define RV_REG_IDX_W 5
`define RV_NREGS 32

// One enable bit per byte lane of a data word
`define RV_MBE_W 4

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// Major opcodes of the supported instruction groups
`define RV_OP_LUI 7'b0110111
`define RV_OP_IMM 7'b0010011
`define RV_OP_REG 7'b0110011
`define RV_OP_LOAD 7'b0000011
`define RV_OP_STORE 7'b0100011

`endif

/* verilog/rv_pkg.sv */
`include "rv_consts.svh"

package rv_pkg;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_t;

  // wb_alu doubles as the bubble encoding
  typedef enum logic [1:0] {
    wb_alu,
    wb_uimm,
    wb_mdr
  } wb_sel_t;

  typedef enum logic [2:0] {
    fwd_stage,
    fwd_mem_alu,
    fwd_mem_uimm,
    fwd_mem_load,
    fwd_wb
  } fwd_sel_t;

  typedef struct packed {
    logic [6:0] funct7;
    logic [`RV_REG_IDX_W-1:0] rs2;
    logic [`RV_REG_IDX_W-1:0] rs1;
    logic [2:0] funct3;
    logic [`RV_REG_IDX_W-1:0] rd;
    logic [6:0] opcode;
  } instr_r_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [`RV_REG_IDX_W-1:0] rs1;
    logic [2:0] funct3;
    logic [`RV_REG_IDX_W-1:0] rd;
    logic [6:0] opcode;
  } instr_i_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [`RV_REG_IDX_W-1:0] rs2;
    logic [`RV_REG_IDX_W-1:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } instr_s_t;

  // Same instruction word seen as R, I or S format
  typedef union packed {
    instr_r_t r;
    instr_i_t i;
    instr_s_t s;
  } instr_u;

  typedef struct packed {
    alu_op_t aluop;
    logic alu_b_imm;
    wb_sel_t wb_sel;
    logic regfile_ld;
    logic dcache_read;
    logic dcache_write;
    logic [2:0] funct3;
  } ctrl_word_t;

  typedef struct packed {
    logic [`RV_XLEN-1:0] address;
    logic read;
    logic write;
    logic [`RV_XLEN-1:0] wdata;
    logic [`RV_MBE_W-1:0] mbe;
  } dmem_req_t;

  typedef struct packed {
    ctrl_word_t ctrl;
    logic [`RV_REG_IDX_W-1:0] rs1;
    logic [`RV_REG_IDX_W-1:0] rs2;
    logic [`RV_REG_IDX_W-1:0] rd;
    logic [`RV_XLEN-1:0] immediate;
    logic [`RV_XLEN-1:0] u_imm;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
  } idex_t;

  typedef struct packed {
    ctrl_word_t ctrl;
    logic [`RV_REG_IDX_W-1:0] rd;
    logic [`RV_XLEN-1:0] u_imm;
    logic [`RV_XLEN-1:0] alu;
    logic [`RV_XLEN-1:0] rs2_data;
  } exmem_t;

  typedef struct packed {
    ctrl_word_t ctrl;
    logic [`RV_REG_IDX_W-1:0] rd;
    logic [`RV_XLEN-1:0] alu;
    logic [`RV_XLEN-1:0] u_imm;
    logic [`RV_XLEN-1:0] mdr;
  } memwb_t;

endpackage

/* verilog/ctrl_rom.sv */
`timescale 1ns/1ns
`include "rv_consts.svh"

module ctrl_rom (
  input  rv_pkg::instr_u instr,
  output rv_pkg::ctrl_word_t ctrl
);

  // funct3 picks the operation, alt selects sub or sra
  function automatic rv_pkg::alu_op_t alu_fn(input logic [2:0] funct3, input logic alt);
    case (funct3)
      3'b000: return alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
      3'b001: return rv_pkg::alu_sll;
      3'b010: return rv_pkg::alu_slt;
      3'b011: return rv_pkg::alu_sltu;
      3'b100: return rv_pkg::alu_xor;
      3'b101: return alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
      3'b110: return rv_pkg::alu_or;
      default: return rv_pkg::alu_and;
    endcase
  endfunction

  always_comb begin
    ctrl = '0;
    case (instr.r.opcode)
      `RV_OP_LUI: begin
        ctrl.wb_sel = rv_pkg::wb_uimm;
        ctrl.regfile_ld = 1'b1;
      end
      `RV_OP_IMM: begin
        // Only srai takes bit 30 of the immediate as a select
        ctrl.aluop = alu_fn(instr.r.funct3, instr.r.funct3 == 3'b101 && instr.r.funct7[5]);
        ctrl.alu_b_imm = 1'b1;
        ctrl.regfile_ld = 1'b1;
        ctrl.funct3 = instr.r.funct3;
      end
      `RV_OP_REG: begin
        ctrl.aluop = alu_fn(instr.r.funct3, instr.r.funct7[5]);
        ctrl.regfile_ld = 1'b1;
        ctrl.funct3 = instr.r.funct3;
      end
      `RV_OP_LOAD: begin
        ctrl.aluop = rv_pkg::alu_add;
        ctrl.alu_b_imm = 1'b1;
        ctrl.wb_sel = rv_pkg::wb_mdr;
        ctrl.regfile_ld = 1'b1;
        ctrl.dcache_read = 1'b1;
        ctrl.funct3 = instr.r.funct3;
      end
      `RV_OP_STORE: begin
        ctrl.aluop = rv_pkg::alu_add;
        ctrl.alu_b_imm = 1'b1;
        ctrl.dcache_write = 1'b1;
        ctrl.funct3 = instr.r.funct3;
      end
      default: begin
        ctrl = '0;
      end
    endcase
  end

endmodule

/* verilog/regfile.sv */
`timescale 1ns/1ns
`include "rv_consts.svh"

module regfile (
  input  logic clk,
  input  logic rst_n,
  input  logic load,
  input  logic [`RV_REG_IDX_W-1:0] rd,
  input  logic [`RV_XLEN-1:0] wdata,
  input  logic [`RV_REG_IDX_W-1:0] rs1,
  input  logic [`RV_REG_IDX_W-1:0] rs2,
  output logic [`RV_XLEN-1:0] rs1_data,
  output logic [`RV_XLEN-1:0] rs2_data
);

  // x0 has no storage
  logic [`RV_XLEN-1:0] regs [1:`RV_NREGS-1];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int k = 1; k < `RV_NREGS; k++) begin
        regs[k] <= '0;
      end
    end else if (load && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  // Write-first so decode sees the value retiring this cycle
  function automatic logic [`RV_XLEN-1:0] read_port(input logic [`RV_REG_IDX_W-1:0] idx);
    if (idx == '0) begin
      return '0;
    end
    if (load && rd == idx) begin
      return wdata;
    end
    return regs[idx];
  endfunction

  always_comb begin
    rs1_data = read_port(rs1);
    rs2_data = read_port(rs2);
  end

endmodule

/* verilog/alu.sv */
`timescale 1ns/1ns
`include "rv_consts.svh"

module alu (
  input  rv_pkg::alu_op_t aluop,
  input  logic [`RV_XLEN-1:0] a,
  input  logic [`RV_XLEN-1:0] b,
  output logic [`RV_XLEN-1:0] f
);

  logic [4:0] shamt;
  logic lt_signed;
  logic lt_unsigned;

  assign shamt = b[4:0];
  assign lt_signed = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (aluop)
      rv_pkg::alu_add: f = a + b;
      rv_pkg::alu_sub: f = a - b;
      rv_pkg::alu_sll: f = a << shamt;
      rv_pkg::alu_slt: f = {{(`RV_XLEN-1){1'b0}}, lt_signed};
      rv_pkg::alu_sltu: f = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
      rv_pkg::alu_xor: f = a ^ b;
      rv_pkg::alu_srl: f = a >> shamt;
      rv_pkg::alu_sra: f = $unsigned($signed(a) >>> shamt);
      rv_pkg::alu_or: f = a | b;
      rv_pkg::alu_and: f = a & b;
      default: f = a + b;
    endcase
  end

endmodule

/* verilog/forwarding_unit.sv */
`timescale 1ns/1ns
`include "rv_consts.svh"

module forwarding_unit (
  input  rv_pkg::idex_t idex,
  input  rv_pkg::exmem_t exmem,
  input  rv_pkg::memwb_t memwb,
  output rv_pkg::fwd_sel_t fwd_a,
  output rv_pkg::fwd_sel_t fwd_b
);

  // Memory stage is younger, so it is checked first
  function automatic rv_pkg::fwd_sel_t pick(input logic [`RV_REG_IDX_W-1:0] src);
    if (exmem.ctrl.regfile_ld && exmem.rd != '0 && exmem.rd == src) begin
      case (exmem.ctrl.wb_sel)
        rv_pkg::wb_uimm: return rv_pkg::fwd_mem_uimm;
        rv_pkg::wb_mdr: return rv_pkg::fwd_mem_load;
        default: return rv_pkg::fwd_mem_alu;
      endcase
    end
    if (memwb.ctrl.regfile_ld && memwb.rd != '0 && memwb.rd == src) begin
      return rv_pkg::fwd_wb;
    end
    return rv_pkg::fwd_stage;
  endfunction

  always_comb begin
    fwd_a = pick(idex.rs1);
    fwd_b = pick(idex.rs2);
  end

endmodule

/* verilog/mem_align.sv */
`timescale 1ns/1ns
`include "rv_consts.svh"

module mem_align (
  input  logic [2:0] funct3,
  input  logic [1:0] addr_low,
  input  logic [`RV_XLEN-1:0] store_data,
  input  logic [`RV_XLEN-1:0] rdata,
  output logic [`RV_XLEN-1:0] wdata,
  output logic [`RV_MBE_W-1:0] mbe,
  output logic [`RV_XLEN-1:0] load_data
);

  logic [4:0] bit_shift;
  logic [7:0] byte_sel;
  logic [15:0] half_sel;
  logic half_ok;
  logic sign_ext;

  assign bit_shift = {addr_low, 3'b000};
  // funct3 bit 2 marks lbu and lhu
  assign sign_ext = ~funct3[2];

  // Store lanes
  always_comb begin
    case (funct3[1:0])
      2'b00: begin
        wdata = store_data << bit_shift;
        mbe = 4'b0001 << addr_low;
      end
      2'b01: begin
        wdata = store_data << bit_shift;
        // Upper lanes fall off at offset 3
        mbe = 4'b0011 << addr_low;
      end
      default: begin
        wdata = store_data;
        mbe = '1;
      end
    endcase
  end

  // Load lanes
  always_comb begin
    byte_sel = rdata[bit_shift +: 8];
    half_ok = 1'b1;
    case (addr_low)
      2'b00: half_sel = rdata[15:0];
      2'b10: half_sel = rdata[31:16];
      default: begin
        half_sel = '0;
        half_ok = 1'b0;
      end
    endcase
    case (funct3[1:0])
      2'b00: load_data = {{(`RV_XLEN-8){sign_ext & byte_sel[7]}}, byte_sel};
      2'b01: begin
        if (half_ok) begin
          load_data = {{(`RV_XLEN-16){sign_ext & half_sel[15]}}, half_sel};
        end else begin
          load_data = '0;
        end
      end
      default: load_data = rdata;
    endcase
  end

endmodule

/* verilog/datapath.sv */
`timescale 1ns/1ns
`include "rv_consts.svh"

module datapath (
  input  logic clk,
  input  logic rst_n,
  input  logic icache_resp,
  input  logic [`RV_XLEN-1:0] icache_rdata,
  output logic [`RV_XLEN-1:0] icache_address,
  output logic icache_read,
  input  logic dcache_resp,
  input  logic [`RV_XLEN-1:0] dcache_rdata,
  output rv_pkg::dmem_req_t dcache_req
);

  logic [`RV_XLEN-1:0] pc;
  logic stall;

  rv_pkg::instr_u ifid_instr;
  rv_pkg::idex_t idex;
  rv_pkg::idex_t idex_d;
  rv_pkg::exmem_t exmem;
  rv_pkg::exmem_t exmem_d;
  rv_pkg::memwb_t memwb;
  rv_pkg::memwb_t memwb_d;

  rv_pkg::ctrl_word_t id_ctrl;
  logic [`RV_XLEN-1:0] id_rs1_data;
  logic [`RV_XLEN-1:0] id_rs2_data;

  rv_pkg::fwd_sel_t fwd_a;
  rv_pkg::fwd_sel_t fwd_b;
  logic [`RV_XLEN-1:0] ex_a;
  logic [`RV_XLEN-1:0] ex_rs2;
  logic [`RV_XLEN-1:0] alu_f;

  logic [`RV_XLEN-1:0] mem_wdata;
  logic [`RV_MBE_W-1:0] mem_mbe;
  logic [`RV_XLEN-1:0] mem_load_data;
  logic [`RV_XLEN-1:0] wb_value;

  // Whole pipeline freezes while either port waits
  assign stall = (icache_read & ~icache_resp) |
                 ((dcache_req.read | dcache_req.write) & ~dcache_resp);

  // Fetch
  assign icache_address = pc;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      icache_read <= 1'b0;
      pc <= `RV_RESET_PC;
    end else begin
      icache_read <= 1'b1;
      if (icache_read && !stall) begin
        pc <= pc + 4;
      end
    end
  end

  // Decode
  ctrl_rom u_ctrl_rom (
    .instr(ifid_instr),
    .ctrl(id_ctrl)
  );

  regfile u_regfile (
    .clk(clk),
    .rst_n(rst_n),
    .load(memwb.ctrl.regfile_ld),
    .rd(memwb.rd),
    .wdata(wb_value),
    .rs1(ifid_instr.r.rs1),
    .rs2(ifid_instr.r.rs2),
    .rs1_data(id_rs1_data),
    .rs2_data(id_rs2_data)
  );

  always_comb begin
    idex_d.ctrl = id_ctrl;
    idex_d.rs1 = ifid_instr.r.rs1;
    idex_d.rs2 = ifid_instr.r.rs2;
    idex_d.rd = ifid_instr.r.rd;
    // Stores take the split S immediate, everything else the I immediate
    if (id_ctrl.dcache_write) begin
      idex_d.immediate = {{(`RV_XLEN-12){ifid_instr.s.imm_hi[6]}},
                          ifid_instr.s.imm_hi, ifid_instr.s.imm_lo};
    end else begin
      idex_d.immediate = {{(`RV_XLEN-12){ifid_instr.i.imm[11]}}, ifid_instr.i.imm};
    end
    idex_d.u_imm = {ifid_instr.i.imm, ifid_instr.i.rs1, ifid_instr.i.funct3, 12'h000};
    idex_d.rs1_data = id_rs1_data;
    idex_d.rs2_data = id_rs2_data;
  end

  // Execute
  forwarding_unit u_forwarding_unit (
    .idex(idex),
    .exmem(exmem),
    .memwb(memwb),
    .fwd_a(fwd_a),
    .fwd_b(fwd_b)
  );

  function automatic logic [`RV_XLEN-1:0] fwd_value(input rv_pkg::fwd_sel_t sel,
                                                    input logic [`RV_XLEN-1:0] stage_val);
    case (sel)
      rv_pkg::fwd_mem_alu: return exmem.alu;
      rv_pkg::fwd_mem_uimm: return exmem.u_imm;
      rv_pkg::fwd_mem_load: return mem_load_data;
      rv_pkg::fwd_wb: return wb_value;
      default: return stage_val;
    endcase
  endfunction

  always_comb begin
    ex_a = fwd_value(fwd_a, idex.rs1_data);
    ex_rs2 = fwd_value(fwd_b, idex.rs2_data);
  end

  alu u_alu (
    .aluop(idex.ctrl.aluop),
    .a(ex_a),
    .b(idex.ctrl.alu_b_imm ? idex.immediate : ex_rs2),
    .f(alu_f)
  );

  always_comb begin
    exmem_d.ctrl = idex.ctrl;
    exmem_d.rd = idex.rd;
    exmem_d.u_imm = idex.u_imm;
    exmem_d.alu = alu_f;
    exmem_d.rs2_data = ex_rs2;
  end

  // Memory
  mem_align u_mem_align (
    .funct3(exmem.ctrl.funct3),
    .addr_low(exmem.alu[1:0]),
    .store_data(exmem.rs2_data),
    .rdata(dcache_rdata),
    .wdata(mem_wdata),
    .mbe(mem_mbe),
    .load_data(mem_load_data)
  );

  always_comb begin
    dcache_req.address = {exmem.alu[`RV_XLEN-1:2], 2'b00};
    dcache_req.read = exmem.ctrl.dcache_read;
    dcache_req.write = exmem.ctrl.dcache_write;
    dcache_req.wdata = mem_wdata;
    dcache_req.mbe = exmem.ctrl.dcache_write ? mem_mbe : '0;
    memwb_d.ctrl = exmem.ctrl;
    memwb_d.rd = exmem.rd;
    memwb_d.alu = exmem.alu;
    memwb_d.u_imm = exmem.u_imm;
    memwb_d.mdr = mem_load_data;
  end

  // Writeback
  always_comb begin
    case (memwb.ctrl.wb_sel)
      rv_pkg::wb_uimm: wb_value = memwb.u_imm;
      rv_pkg::wb_mdr: wb_value = memwb.mdr;
      default: wb_value = memwb.alu;
    endcase
  end

  // A bubble enters decode when nothing was fetched
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ifid_instr <= '0;
      idex.ctrl <= '0;
      exmem.ctrl <= '0;
      memwb.ctrl <= '0;
    end else if (!stall) begin
      ifid_instr <= icache_read ? icache_rdata : '0;
      idex <= idex_d;
      exmem <= exmem_d;
      memwb <= memwb_d;
    end
  end

endmodule

/* tb/datapath_sva.sv */
`timescale 1ns/1ns

module datapath_sva (
  input logic clk,
  input logic rst_n,
  input logic icache_read,
  input logic dcache_resp,
  input rv_pkg::dmem_req_t dcache_req
);

  // Number of failed assertions
  int assert_fails = 0;

  // A data request is a load or a store, never both
  read_write_exclusive: assert property (
    @(posedge clk) disable iff (!rst_n) !(dcache_req.read && dcache_req.write)
  ) else begin
    assert_fails++;
    $error("data request has read and write high together");
  end

  // Pending data request holds until the memory answers
  dreq_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
      (dcache_req.read || dcache_req.write) && !dcache_resp |=> $stable(dcache_req)
  ) else begin
    assert_fails++;
    $error("data request changed before dcache_resp");
  end

  ifetch_idle_in_reset: assert property (
    @(posedge clk) !rst_n |=> !icache_read
  ) else begin
    assert_fails++;
    $error("icache_read high during reset");
  end

endmodule

/* tb/tb_datapath.sv */
`timescale 1ns/1ns
`include "rv_consts.svh"

module tb_datapath;

  localparam int NUM_RANDOM = 200;
  localparam int PROG_LEN = NUM_RANDOM + 7;
  localparam int TIMEOUT_CYCLES = 20000;

  logic clk;
  logic rst_n;
  logic icache_resp;
  logic [`RV_XLEN-1:0] icache_rdata;
  logic [`RV_XLEN-1:0] icache_address;
  logic icache_read;
  logic dcache_resp;
  logic [`RV_XLEN-1:0] dcache_rdata;
  rv_pkg::dmem_req_t dcache_req;

  logic [31:0] lfsr_state;
  logic [31:0] prog [0:PROG_LEN-1];
  logic [31:0] dmem [0:63];
  logic [31:0] model_regs [0:31];
  logic [31:0] model_mem [0:63];
  rv_pkg::dmem_req_t exp_stores [$];

  int mismatches = 0;
  int failures = 0;
  int writes_done = 0;
  int store_total = 0;
  int iwait;
  int dwait;
  logic [31:0] exp_pc;
  logic fetch_taken;
  logic data_taken;
  logic rst_prev;

  datapath u_dut (
    .clk(clk),
    .rst_n(rst_n),
    .icache_resp(icache_resp),
    .icache_rdata(icache_rdata),
    .icache_address(icache_address),
    .icache_read(icache_read),
    .dcache_resp(dcache_resp),
    .dcache_rdata(dcache_rdata),
    .dcache_req(dcache_req)
  );

  bind datapath datapath_sva u_datapath_sva (
    .clk(clk),
    .rst_n(rst_n),
    .icache_read(icache_read),
    .dcache_resp(dcache_resp),
    .dcache_req(dcache_req)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // Every byte of the word depends on the word index
  function automatic logic [31:0] fill_word(input logic [5:0] idx);
    return {2'b10, idx, ~idx, 2'b01, idx ^ 6'h2a, 2'b11, idx + 6'd9, 2'b00};
  endfunction

  // NOPs past the end of the program
  function automatic logic [31:0] fetch_word(input logic [31:0] addr);
    if (addr[31:2] < PROG_LEN) begin
      return prog[addr[31:2]];
    end
    return {12'h000, 5'd0, 3'b000, 5'd0, `RV_OP_IMM};
  endfunction

  function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: begin
        if (alt) begin
          return $unsigned($signed(a) >>> b[4:0]);
        end
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    mismatches++;
    $display("mismatch %s: expected %h actual %h at %0t", name, expected, actual, $time);
  endtask

  // Registers x0..x7 only with x0 as the load and store base
  task automatic build_program();
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [2:0] kind;
    logic [2:0] f3;
    logic [6:0] f7;
    logic [11:0] imm;
    logic [19:0] upper;
    for (int n = 0; n < NUM_RANDOM; n++) begin
      kind = 3'(take_bits(3));
      rd = 5'(take_bits(3));
      rs1 = 5'(take_bits(3));
      rs2 = 5'(take_bits(3));
      f3 = 3'(take_bits(3));
      imm = 12'(take_bits(12));
      case (kind)
        3'd0: begin
          upper = 20'(take_bits(20));
          prog[n] = {upper, rd, `RV_OP_LUI};
        end
        3'd1, 3'd2: begin
          if (f3 == 3'd1) begin
            imm = {7'b0, imm[4:0]};
          end
          if (f3 == 3'd5) begin
            imm = {1'b0, imm[11], 5'b0, imm[4:0]};
          end
          prog[n] = {imm, rs1, f3, rd, `RV_OP_IMM};
        end
        3'd3, 3'd4: begin
          f7 = ((f3 == 3'd0 || f3 == 3'd5) && imm[0]) ? 7'b0100000 : 7'b0;
          prog[n] = {f7, rs2, rs1, f3, rd, `RV_OP_REG};
        end
        3'd5: begin
          // lb lh lw lbu lhu
          f3 = imm[10:8] % 3'd5;
          if (f3 >= 3'd3) begin
            f3 = f3 + 3'd1;
          end
          prog[n] = {4'h0, imm[7:0], 5'd0, f3, rd, `RV_OP_LOAD};
        end
        default: begin
          f3 = imm[10:8] % 3'd3;
          prog[n] = {4'h0, imm[7:5], rs2, 5'd0, f3, imm[4:0], `RV_OP_STORE};
        end
      endcase
    end
    // Dump x1..x7 at the top of data memory
    for (int k = 1; k <= 7; k++) begin
      imm = 12'h0e0 + 12'(4 * k);
      prog[NUM_RANDOM + k - 1] = {imm[11:5], 5'(k), 5'd0, 3'b010, imm[4:0], `RV_OP_STORE};
    end
  endtask

  // In-order executor producing the expected store stream
  task automatic run_model();
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] addr;
    logic [31:0] word;
    logic [31:0] lane;
    logic [31:0] res;
    logic [1:0] off;
    rv_pkg::dmem_req_t st;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    for (int n = 0; n < PROG_LEN; n++) begin
      w = prog[n];
      a = model_regs[w[19:15]];
      b = model_regs[w[24:20]];
      res = '0;
      case (w[6:0])
        `RV_OP_LUI: res = {w[31:12], 12'h000};
        `RV_OP_IMM: res = alu_model(w[14:12], w[14:12] == 3'd5 && w[30], a,
                                    {{20{w[31]}}, w[31:20]});
        `RV_OP_REG: res = alu_model(w[14:12], w[30], a, b);
        `RV_OP_LOAD: begin
          addr = a + {{20{w[31]}}, w[31:20]};
          word = model_mem[addr[7:2]];
          off = addr[1:0];
          lane = word >> {off, 3'b000};
          case (w[14:12])
            3'd0: res = {{24{lane[7]}}, lane[7:0]};
            3'd4: res = {24'h0, lane[7:0]};
            3'd1: res = off[0] ? '0 : {{16{lane[15]}}, lane[15:0]};
            3'd5: res = off[0] ? '0 : {16'h0, lane[15:0]};
            default: res = word;
          endcase
        end
        default: begin
          addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
          off = addr[1:0];
          st.address = {addr[31:2], 2'b00};
          st.read = 1'b0;
          st.write = 1'b1;
          case (w[14:12])
            3'd0: begin
              st.wdata = b << {off, 3'b000};
              st.mbe = 4'b0001 << off;
            end
            3'd1: begin
              st.wdata = b << {off, 3'b000};
              st.mbe = 4'b0011 << off;
            end
            default: begin
              st.wdata = b;
              st.mbe = 4'b1111;
            end
          endcase
          exp_stores.push_back(st);
          for (int k = 0; k < 4; k++) begin
            if (st.mbe[k]) begin
              model_mem[addr[7:2]][8*k +: 8] = st.wdata[8*k +: 8];
            end
          end
        end
      endcase
      if (w[6:0] != `RV_OP_STORE && w[11:7] != 5'd0) begin
        model_regs[w[11:7]] = res;
      end
    end
  endtask

  // Ports are settled by the falling edge
  task automatic observe_cycle();
    logic busy;
    logic stall;
    rv_pkg::dmem_req_t want;
    busy = dcache_req.read | dcache_req.write;
    stall = (icache_read & ~icache_resp) | (busy & ~dcache_resp);
    fetch_taken = icache_read & icache_resp & ~stall;
    data_taken = busy & dcache_resp & ~stall;
    if (!rst_n || !rst_prev) begin
      if ({icache_read, dcache_req.read, dcache_req.write, dcache_req.mbe} !== '0) begin
        report_mismatch("reset", 32'h0, {25'h0, icache_read, dcache_req.read,
                                         dcache_req.write, dcache_req.mbe});
      end
    end
    rst_prev = rst_n;
    if (fetch_taken) begin
      if (icache_address !== exp_pc) begin
        report_mismatch("fetch", exp_pc, icache_address);
      end
      exp_pc = exp_pc + 32'd4;
    end
    if (data_taken && dcache_req.write) begin
      if (exp_stores.size() == 0) begin
        failures++;
        $display("a store completed after the model ran out of expected stores");
      end else begin
        want = exp_stores.pop_front();
        if (dcache_req.address !== want.address) begin
          report_mismatch("store address", want.address, dcache_req.address);
        end
        if (dcache_req.mbe !== want.mbe) begin
          report_mismatch("store mbe", {28'h0, want.mbe}, {28'h0, dcache_req.mbe});
        end
        if (dcache_req.wdata !== want.wdata) begin
          report_mismatch("store wdata", want.wdata, dcache_req.wdata);
        end
      end
      for (int k = 0; k < 4; k++) begin
        if (dcache_req.mbe[k]) begin
          dmem[dcache_req.address[7:2]][8*k +: 8] = dcache_req.wdata[8*k +: 8];
        end
      end
      writes_done++;
    end
  endtask

  // A response is held until the pipeline takes it
  task automatic drive_ports();
    logic busy;
    busy = dcache_req.read | dcache_req.write;
    if (!icache_read) begin
      icache_resp = 1'b0;
      iwait = -1;
    end else if (!icache_resp || fetch_taken) begin
      if (icache_resp || iwait < 0) begin
        iwait = take_bits(2) % 3;
      end else begin
        iwait--;
      end
      icache_resp = (iwait == 0);
      icache_rdata = fetch_word(icache_address);
    end
    if (!busy) begin
      dcache_resp = 1'b0;
      dwait = -1;
    end else if (!dcache_resp || data_taken) begin
      if (dcache_resp || dwait < 0) begin
        dwait = take_bits(2) % 3;
      end else begin
        dwait--;
      end
      dcache_resp = (dwait == 0);
      if (dcache_resp) begin
        dcache_rdata = dmem[dcache_req.address[7:2]];
      end
    end
  endtask

  initial begin : port_model
    @(posedge clk);
    forever begin
      @(negedge clk);
      observe_cycle();
      @(posedge clk);
      #10;
      drive_ports();
    end
  end

  initial begin : main_seq
    int cycles;
    rst_n = 1'b0;
    icache_resp = 1'b0;
    icache_rdata = '0;
    dcache_resp = 1'b0;
    dcache_rdata = '0;
    fetch_taken = 1'b0;
    data_taken = 1'b0;
    rst_prev = 1'b0;
    iwait = -1;
    dwait = -1;
    exp_pc = `RV_RESET_PC;
    lfsr_state = 32'h951a3328;
    build_program();
    for (int i = 0; i < 64; i++) begin
      dmem[i] = fill_word(6'(i));
      model_mem[i] = fill_word(6'(i));
    end
    run_model();
    store_total = exp_stores.size();
    repeat (8) begin
      @(posedge clk);
    end
    #10;
    rst_n = 1'b1;
    cycles = 0;
    while (writes_done < store_total && cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    if (writes_done < store_total) begin
      failures++;
      $display("timeout: only %0d of %0d expected stores completed", writes_done, store_total);
    end
    // Room for a stray extra store to show up
    repeat (50) begin
      @(posedge clk);
    end
    $display("Summary: %0d mismatches, %0d other failures, %0d assertion failures, %0d of %0d stores",
             mismatches, failures, u_dut.u_datapath_sva.assert_fails, writes_done, store_total);
    if (mismatches == 0 && failures == 0 && u_dut.u_datapath_sva.assert_fails == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* sim.f */
+incdir+include
verilog/rv_pkg.sv
verilog/ctrl_rom.sv
verilog/regfile.sv
verilog/alu.sv
verilog/forwarding_unit.sv
verilog/mem_align.sv
verilog/datapath.sv
tb/datapath_sva.sv
tb/tb_datapath.sv
